/* Bender.yml */
package:
  name: wb_interconnect

sources:
  - include_dirs:
      - source
    files:
      - source/wb_ic_pkg.sv
      - source/wb_arb.sv
      - source/wb_master_mux.sv
      - source/wb_stagging.sv
      - source/wb_slave_mux.sv
      - source/wb_interconnect.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_wb_interconnect.sv

/* bench/tb_wb_interconnect.sv */
// Self-checking testbench for the shared bus Wishbone interconnect with slave models
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module tb_wb_interconnect;

  logic               clk;
  logic               arst_n;
  wb_ic_pkg::wb_req_t m_req [`WB_NUM_M];
  wb_ic_pkg::wb_rsp_t m_rsp [`WB_NUM_M];
  wb_ic_pkg::wb_req_t s_req [`WB_NUM_S];
  wb_ic_pkg::wb_rsp_t s_rsp [`WB_NUM_S];

  // Pending request per master as issued before alignment
  logic               out_vld [`WB_NUM_M];
  wb_ic_pkg::wb_req_t out_req [`WB_NUM_M];

  // Checker state for the one transfer in flight
  logic               act = 1'b0;
  logic               due = 1'b0;
  logic               due_we;
  logic [31:0]        due_dat;
  int                 cur_s;
  int                 cur_m;
  int                 due_m;
  wb_ic_pkg::wb_req_t held;

  // Completion order and write log counts
  int done_cnt;
  int done_q [$];
  int wr_issued;
  int wr_seen;

  wb_interconnect u_wb_interconnect (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .m_req_i  (m_req),
    .m_rsp_o  (m_rsp),
    .s_req_o  (s_req),
    .s_rsp_i  (s_rsp)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // --------------------------------------------------------------------
  // Reference decode, word alignment and per-slave trimming
  // --------------------------------------------------------------------
  function automatic int ref_route(input logic [31:0] adr, output logic [31:0] trimmed);
    logic [31:0] a;
    int          tgt;
    a   = {adr[31:2], 2'b00};
    tgt = 0;
    if (a[31:28] == 4'h2)
      tgt = 1;
    else if (a[31:16] == 16'h3000)
      tgt = 2;
    else if (a[31:16] == 16'h3001)
      tgt = 3;
    case (tgt)
      1:       trimmed = {4'h0, a[27:0]};
      2, 3:    trimmed = {24'h0, a[7:0]};
      default: trimmed = a;
    endcase
    return tgt;
  endfunction

  // Random address in a mapped region, a mapped page or an unmapped hole
  function automatic logic [31:0] rand_adr();
    logic [31:0] r;
    r = $urandom;
    case ($urandom % 7)
      0:       r[31:28] = 4'h0;
      1:       r[31:28] = 4'h1;
      2:       r[31:28] = 4'h2;
      3:       r[31:16] = 16'h3000;
      4:       r[31:16] = 16'h3001;
      5:       r[31:16] = 16'h3002 + 16'($urandom % 64);
      default: r[31:28] = 4'h4 + 4'($urandom % 12);
    endcase
    return r;
  endfunction

  task automatic report_fail();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Nothing may strobe or ack around reset
  task automatic check_idle();
    for (int s = 0; s < `WB_NUM_S; s++) begin
      assert (!s_req[s].stb && !s_req[s].cyc) else begin
        $display("MISMATCH %0t ns: slave %0d strobe active around reset", $time, s);
        report_fail();
      end
    end
    for (int m = 0; m < `WB_NUM_M; m++) begin
      assert (!m_rsp[m].ack) else begin
        $display("MISMATCH %0t ns: master %0d ack active around reset", $time, m);
        report_fail();
      end
    end
  endtask

  // --------------------------------------------------------------------
  // Master driver called on a rising edge
  // --------------------------------------------------------------------
  task automatic do_xfer(input int m, input wb_ic_pkg::wb_req_t r);
    int start;
    int waited;
    start      = done_cnt;
    waited     = 0;
    out_req[m] = r;
    out_vld[m] = 1'b1;
    if (r.we)
      wr_issued++;
    m_req[m] <= r;
    // Hold every field until ack is sampled
    do begin
      @(posedge clk);
      waited++;
      if (waited > 200) begin
        $display("Timeout, master %0d got no ack within 200 cycles", m);
        report_fail();
      end
    end while (!m_rsp[m].ack);
    // Round robin lets at most two other transfers go first
    assert (done_cnt - start <= 2) else begin
      $display("MISMATCH %0t ns: master %0d waited %0d transfers", $time, m, done_cnt - start);
      report_fail();
    end
    done_cnt++;
    done_q.push_back(m);
    out_vld[m] = 1'b0;
    m_req[m]  <= '0;
  endtask

  task automatic run_master(input int m, input int n);
    wb_ic_pkg::wb_req_t r;
    for (int i = 0; i < n; i++) begin
      r     = '0;
      r.adr = rand_adr();
      r.dat = $urandom;
      r.sel = 4'($urandom);
      r.we  = 1'($urandom);
      r.cyc = 1'b1;
      r.stb = 1'b1;
      do_xfer(m, r);
    end
  endtask

  // --------------------------------------------------------------------
  // Slave models with a random 0 to 5 cycle ack delay
  // --------------------------------------------------------------------
  for (genvar s = 0; s < `WB_NUM_S; s++) begin : g_slave
    wb_ic_pkg::wb_rsp_t rsp = '0;
    int                 dly = -1;
    assign s_rsp[s] = rsp;
    always @(posedge clk) begin
      if (rsp.ack) begin
        rsp <= '0;
      end else if (s_req[s].stb) begin
        if (dly < 0)
          dly = $urandom % 6;
        if (dly == 0) begin
          // Slave index in the top byte over the received address
          rsp.ack <= 1'b1;
          rsp.dat <= {8'(s), 24'h0} ^ s_req[s].adr;
          if (s_req[s].we)
            wr_seen++;
          dly = -1;
        end else begin
          dly--;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Checker on both bus sides
  // --------------------------------------------------------------------
  always @(posedge clk) begin
    int                 n_stb;
    int                 hit_s;
    int                 hit_m;
    logic [31:0]        tadr;
    wb_ic_pkg::wb_req_t exp_r;
    if (arst_n) begin
      // Ack only to the issuing master one cycle after the slave ack
      for (int m = 0; m < `WB_NUM_M; m++) begin
        assert (m_rsp[m].ack == (due && due_m == m)) else begin
          $display("MISMATCH %0t ns: master %0d ack is %0b", $time, m, m_rsp[m].ack);
          report_fail();
        end
        if (m_rsp[m].ack && !due_we) begin
          assert (m_rsp[m].dat == due_dat) else begin
            $display("MISMATCH %0t ns: master %0d read %h expected %h", $time, m,
                     m_rsp[m].dat, due_dat);
            report_fail();
          end
        end
      end
      due   = 1'b0;
      n_stb = 0;
      hit_s = -1;
      for (int s = 0; s < `WB_NUM_S; s++) begin
        if (s_req[s].stb) begin
          n_stb++;
          hit_s = s;
        end
      end
      assert (n_stb <= 1) else begin
        $display("MISMATCH %0t ns: %0d slave strobes high together", $time, n_stb);
        report_fail();
      end
      if (hit_s >= 0 && !act) begin
        // New transfer must match one pending master request exactly
        hit_m = -1;
        for (int m = 0; m < `WB_NUM_M; m++) begin
          if (out_vld[m] && hit_m < 0) begin
            exp_r     = out_req[m];
            exp_r.cyc = 1'b1;
            exp_r.stb = 1'b1;
            if (ref_route(out_req[m].adr, tadr) == hit_s) begin
              exp_r.adr = tadr;
              if (exp_r == s_req[hit_s])
                hit_m = m;
            end
          end
        end
        assert (hit_m >= 0) else begin
          $display("MISMATCH %0t ns: slave %0d got adr %h dat %h from no master", $time,
                   hit_s, s_req[hit_s].adr, s_req[hit_s].dat);
          report_fail();
        end
        act   = 1'b1;
        cur_s = hit_s;
        cur_m = hit_m;
        held  = exp_r;
      end else if (act) begin
        // Request stays put through back-pressure
        assert (hit_s == cur_s && s_req[cur_s] == held) else begin
          $display("MISMATCH %0t ns: slave %0d request changed before ack", $time, cur_s);
          report_fail();
        end
      end
      if (act && s_rsp[cur_s].ack) begin
        due     = 1'b1;
        due_m   = cur_m;
        due_we  = held.we;
        due_dat = {8'(cur_s), 24'h0} ^ held.adr;
        act     = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    void'($urandom(16219));
    $timeformat(-9, 0, "", 0);
    clk       = 1'b0;
    arst_n    = 1'b0;
    done_cnt  = 0;
    wr_issued = 0;
    wr_seen   = 0;
    for (int m = 0; m < `WB_NUM_M; m++) begin
      m_req[m]   = '0;
      out_vld[m] = 1'b0;
    end
    repeat (4) begin
      @(posedge clk);
      check_idle();
    end
    arst_n <= 1'b1;
    @(posedge clk);
    check_idle();
    // All masters at once right after reset are served m0 then m1 then m2
    fork
      run_master(0, 1);
      run_master(1, 1);
      run_master(2, 1);
    join
    assert (done_q.size() == 3 && done_q[0] == 0 && done_q[1] == 1 && done_q[2] == 2) else begin
      $display("MISMATCH %0t ns: first grants out of round-robin order", $time);
      report_fail();
    end
    // Continuous random traffic from every master
    fork
      run_master(0, 24);
      run_master(1, 24);
      run_master(2, 24);
    join
    @(posedge clk);
    assert (wr_seen == wr_issued) else begin
      $display("MISMATCH %0t ns: slaves logged %0d writes of %0d", $time, wr_seen, wr_issued);
      report_fail();
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* source/wb_arb.sv */
// Round-robin arbiter granting the shared bus to one of the masters
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module wb_arb (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [`WB_NUM_M-1:0] req_i,
  output logic [`WB_GNT_W-1:0] gnt_o
);

  // Current and next grant
  logic [`WB_GNT_W-1:0] gnt_q;
  logic [`WB_GNT_W-1:0] gnt_nxt;

  // ----------------------------------------------------------------------
  // Next grant
  // ----------------------------------------------------------------------
  // Holder keeps the bus while its request stays high
  // Once it falls search the others in rotation order after the holder
  // Loop runs from the farthest to the nearest so the nearest wins
  always_comb begin
    int idx;
    gnt_nxt = gnt_q;
    idx     = 0;
    if (!req_i[gnt_q]) begin
      for (int k = `WB_NUM_M - 1; k > 0; k--) begin
        idx = (gnt_q + k) % `WB_NUM_M;
        if (req_i[idx]) begin
          gnt_nxt = idx[`WB_GNT_W-1:0];
        end
      end
    end
    // No requester at all leaves the grant where it is
  end

  // ----------------------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------------------
  // Starts at master 0 out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_nxt;
    end
  end

  // Registered grant goes straight out
  assign gnt_o = gnt_q;

endmodule

/* source/wb_ic_macros.svh */
// Wishbone interconnect macros for bus widths, port counts and the fixed address map
`ifndef WB_IC_MACROS_SVH
`define WB_IC_MACROS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define WB_DW        32
`define WB_AW        32
`define WB_SW        4

// Port counts
`define WB_NUM_M     3
`define WB_NUM_S     4

// Target id and grant widths
`define WB_TID_W     2
`define WB_GNT_W     2

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
// Two decode views of one address word
`define WB_RGN_W     4
`define WB_PAGE_W    16

// Top nibble regions
`define WB_RGN_FLASH  4'h0
`define WB_RGN_SPIREG 4'h1
`define WB_RGN_SDRAM  4'h2

// 64 KB pages inside region 3
`define WB_PAGE_GLBL  16'h3000
`define WB_PAGE_UART  16'h3001

// Register slaves only decode the low byte
`define WB_SHORT_AW  8

`endif

/* source/wb_ic_pkg.sv */
// Wishbone interconnect types for requests, responses, target ids and address decode
`include "wb_ic_macros.svh"

package wb_ic_pkg;

  // --------------------------------------------------------------------
  // Target slave index
  // --------------------------------------------------------------------
  typedef logic [`WB_TID_W-1:0] wb_tid_t;

  // --------------------------------------------------------------------
  // Address word with region and page views
  // --------------------------------------------------------------------
  // Region view splits off the top nibble
  typedef struct packed {
    logic [`WB_RGN_W-1:0]        rgn;
    logic [`WB_AW-`WB_RGN_W-1:0] off;
  } wb_adr_rgn_t;

  // Page view splits off the upper half word
  typedef struct packed {
    logic [`WB_PAGE_W-1:0]        page;
    logic [`WB_AW-`WB_PAGE_W-1:0] off;
  } wb_adr_page_t;

  // Same 32 bits read both ways by the decoder
  typedef union packed {
    wb_adr_rgn_t  rgn_v;
    wb_adr_page_t page_v;
  } wb_addr_u;

  // --------------------------------------------------------------------
  // Bus payloads
  // --------------------------------------------------------------------
  // Master to slave direction
  typedef struct packed {
    logic [`WB_DW-1:0] dat;
    logic [`WB_AW-1:0] adr;
    logic [`WB_SW-1:0] sel;
    logic              we;
    logic              cyc;
    logic              stb;
  } wb_req_t;

  // Request tagged with its decoded target
  typedef struct packed {
    wb_req_t req;
    wb_tid_t tid;
  } wb_treq_t;

  // Slave to master direction
  typedef struct packed {
    logic [`WB_DW-1:0] dat;
    logic              ack;
  } wb_rsp_t;

endpackage

/* source/wb_interconnect.sv */
// Shared bus Wishbone interconnect joining three masters to four slaves
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module wb_interconnect (
  input  logic               clk_i,
  input  logic               arst_n_i,

  // Masters
  // m0 external host
  // m1 RISC instruction port
  // m2 RISC data port
  input  wb_ic_pkg::wb_req_t m_req_i [`WB_NUM_M],
  output wb_ic_pkg::wb_rsp_t m_rsp_o [`WB_NUM_M],

  // Slaves
  // s0 SPI flash and registers
  // s1 SDRAM
  // s2 global registers
  // s3 UART
  output wb_ic_pkg::wb_req_t s_req_o [`WB_NUM_S],
  input  wb_ic_pkg::wb_rsp_t s_rsp_i [`WB_NUM_S]
);

  // ----------------------------------------------------------------------
  // Internal buses
  // ----------------------------------------------------------------------
  // Pending requests toward the arbiter
  logic [`WB_NUM_M-1:0] req_vec;
  // Registered grant
  logic [`WB_GNT_W-1:0] gnt;

  // Master side of the staging stage
  wb_ic_pkg::wb_treq_t  mbus_req;
  wb_ic_pkg::wb_rsp_t   mbus_rsp;

  // Slave side of the staging stage
  wb_ic_pkg::wb_treq_t  sbus_req;
  wb_ic_pkg::wb_rsp_t   sbus_rsp;

  // ----------------------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------------------
  wb_arb u_wb_arb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_vec),
    .gnt_o    (gnt)
  );

  // ----------------------------------------------------------------------
  // Master side
  // ----------------------------------------------------------------------
  // Decode and select the granted master
  wb_master_mux u_wb_master_mux (
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .gnt_i      (gnt),
    .req_vec_o  (req_vec),
    .mbus_req_o (mbus_req),
    .mbus_rsp_i (mbus_rsp)
  );

  // ----------------------------------------------------------------------
  // Staging stage
  // ----------------------------------------------------------------------
  // Breaks both the request and response timing paths
  wb_stagging u_m_wb_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .mbus_req_i (mbus_req),
    .mbus_rsp_o (mbus_rsp),
    .sbus_req_o (sbus_req),
    .sbus_rsp_i (sbus_rsp)
  );

  // ----------------------------------------------------------------------
  // Slave side
  // ----------------------------------------------------------------------
  // Route by target id and trim addresses
  wb_slave_mux u_wb_slave_mux (
    .sbus_req_i (sbus_req),
    .sbus_rsp_o (sbus_rsp),
    .s_req_o    (s_req_o),
    .s_rsp_i    (s_rsp_i)
  );

endmodule

/* source/wb_master_mux.sv */
// Master side mux with address decode, grant-based request select and response return
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module wb_master_mux (
  input  wb_ic_pkg::wb_req_t   m_req_i [`WB_NUM_M],
  output wb_ic_pkg::wb_rsp_t   m_rsp_o [`WB_NUM_M],
  input  logic [`WB_GNT_W-1:0] gnt_i,
  output logic [`WB_NUM_M-1:0] req_vec_o,
  output wb_ic_pkg::wb_treq_t  mbus_req_o,
  input  wb_ic_pkg::wb_rsp_t   mbus_rsp_i
);

  // Tagged and aligned request per master
  wb_ic_pkg::wb_treq_t m_treq [`WB_NUM_M];

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  // 0x0xxx_xxxx and 0x1xxx_xxxx   flash and SPI registers on slave 0
  // 0x2xxx_xxxx                   SDRAM on slave 1
  // 0x3000_xxxx                   global registers on slave 2
  // 0x3001_xxxx                   UART on slave 3
  // Anything else falls back to slave 0
  always_comb begin
    wb_ic_pkg::wb_addr_u adr_u;
    adr_u = '0;
    for (int m = 0; m < `WB_NUM_M; m++) begin
      adr_u = m_req_i[m].adr;

      // Region view first then page view
      if ((adr_u.rgn_v.rgn == `WB_RGN_FLASH) || (adr_u.rgn_v.rgn == `WB_RGN_SPIREG)) begin
        m_treq[m].tid = wb_ic_pkg::wb_tid_t'(0);
      end else if (adr_u.rgn_v.rgn == `WB_RGN_SDRAM) begin
        m_treq[m].tid = wb_ic_pkg::wb_tid_t'(1);
      end else if (adr_u.page_v.page == `WB_PAGE_GLBL) begin
        m_treq[m].tid = wb_ic_pkg::wb_tid_t'(2);
      end else if (adr_u.page_v.page == `WB_PAGE_UART) begin
        m_treq[m].tid = wb_ic_pkg::wb_tid_t'(3);
      end else begin
        m_treq[m].tid = wb_ic_pkg::wb_tid_t'(0);
      end

      // Payload passes as is
      m_treq[m].req     = m_req_i[m];
      // Word aligned address
      m_treq[m].req.adr = {m_req_i[m].adr[`WB_AW-1:2], 2'b00};
    end
  end

  // ----------------------------------------------------------------------
  // Request select
  // ----------------------------------------------------------------------
  // Granted master drives the shared bus
  always_comb begin
    mbus_req_o = m_treq[0];
    for (int m = 0; m < `WB_NUM_M; m++) begin
      if (gnt_i == m) begin
        mbus_req_o = m_treq[m];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response return and request vector
  // ----------------------------------------------------------------------
  // Only the granted master sees data and ack
  // A master stops requesting in the cycle its ack comes back
  always_comb begin
    for (int m = 0; m < `WB_NUM_M; m++) begin
      m_rsp_o[m]   = (gnt_i == m) ? mbus_rsp_i : '0;
      req_vec_o[m] = m_req_i[m].stb & ~m_rsp_o[m].ack;
    end
  end

endmodule

/* source/wb_slave_mux.sv */
// Slave side mux routing the staged request by target id with address trimming
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module wb_slave_mux (
  input  wb_ic_pkg::wb_treq_t sbus_req_i,
  output wb_ic_pkg::wb_rsp_t  sbus_rsp_o,
  output wb_ic_pkg::wb_req_t  s_req_o [`WB_NUM_S],
  input  wb_ic_pkg::wb_rsp_t  s_rsp_i [`WB_NUM_S]
);

  // ----------------------------------------------------------------------
  // Address trimming per slave
  // ----------------------------------------------------------------------
  // Slave 0 takes the full address
  // Slave 1 drops the region nibble
  // Slaves 2 and 3 keep the low byte only
  function automatic logic [`WB_AW-1:0] trim_adr(input int sidx,
                                                 input logic [`WB_AW-1:0] adr);
    logic [`WB_AW-1:0] res;
    res = adr;
    case (sidx)
      1: begin
        res = {{`WB_RGN_W{1'b0}}, adr[`WB_AW-`WB_RGN_W-1:0]};
      end
      2, 3: begin
        res = {{(`WB_AW-`WB_SHORT_AW){1'b0}}, adr[`WB_SHORT_AW-1:0]};
      end
      default: begin
        res = adr;
      end
    endcase
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // Request routing
  // ----------------------------------------------------------------------
  // Target gets the request and every other slave sees all zero
  always_comb begin
    for (int s = 0; s < `WB_NUM_S; s++) begin
      s_req_o[s] = '0;
      if (sbus_req_i.tid == s) begin
        s_req_o[s]     = sbus_req_i.req;
        s_req_o[s].adr = trim_adr(s, sbus_req_i.req.adr);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response select
  // ----------------------------------------------------------------------
  // tid covers exactly the slave range
  always_comb begin
    sbus_rsp_o = s_rsp_i[0];
    for (int s = 0; s < `WB_NUM_S; s++) begin
      if (sbus_req_i.tid == s) begin
        sbus_rsp_o = s_rsp_i[s];
      end
    end
  end

endmodule

/* source/wb_stagging.sv */
// Staging register holding one Wishbone transfer between master and slave sides
`timescale 1ns/10ps
`include "wb_ic_macros.svh"

module wb_stagging (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  wb_ic_pkg::wb_treq_t mbus_req_i,
  output wb_ic_pkg::wb_rsp_t  mbus_rsp_o,
  output wb_ic_pkg::wb_treq_t sbus_req_o,
  input  wb_ic_pkg::wb_rsp_t  sbus_rsp_i
);

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  // Transfer in flight on the slave side
  logic                busy_q;
  // Captured request fields
  wb_ic_pkg::wb_treq_t req_q;
  // Returned response toward the master side
  logic                ack_q;
  logic [`WB_DW-1:0]   dat_q;

  // Capture and completion strobes
  logic                capture;
  logic                done;

  // Idle and master strobing
  // Not while our own ack is out since the master still holds stb then
  assign capture = ~busy_q & mbus_req_i.req.stb & ~ack_q;

  // Slave acked the staged request
  assign done    = busy_q & sbus_rsp_i.ack;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      if (capture) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      // One cycle pulse one cycle after the slave ack
      ack_q <= done;
    end
  end

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------
  // Request held stable through slave back-pressure
  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= mbus_req_i;
    end
  end

  // Read data latched with the ack
  always_ff @(posedge clk_i) begin
    if (done) begin
      dat_q <= sbus_rsp_i.dat;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  // Slave side stb and cyc follow the busy flag
  always_comb begin
    sbus_req_o         = req_q;
    sbus_req_o.req.stb = busy_q;
    sbus_req_o.req.cyc = busy_q;
  end

  // Master side response
  always_comb begin
    mbus_rsp_o.dat = dat_q;
    mbus_rsp_o.ack = ack_q;
  end

endmodule

/* tb.f */
+incdir+source
source/wb_ic_pkg.sv
source/wb_arb.sv
source/wb_master_mux.sv
source/wb_stagging.sv
source/wb_slave_mux.sv
source/wb_interconnect.sv
bench/tb_wb_interconnect.sv
